//--- ahb_slave.f
ahb_pkg.sv
slave_mem_pkg.sv
burst_addr_calc.sv
ahb_addr_phase.sv
byte_mem_stage.sv
ahb_slave.sv
tb_clk_gen.sv
tb_ahb_slave.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal --top-module tb_ahb_slave -f ahb_slave.f
	out=$$(./obj_dir/Vtb_ahb_slave); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- tb_ahb_slave.sv
`timescale 1ns/100ps

module tb_ahb_slave;

    import ahb_pkg::*;
    import slave_mem_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_SINGLE   = 200;
    localparam int N_INCR     = 24;
    localparam int N_OOR      = 16;
    localparam int N_PIPE     = 40;
    // upper bound of clock cycles over all tests, reset included
    localparam int TOTAL_BEATS = 10 + 3 + (N_SINGLE + 1) + (N_INCR * 32 + 1)
                               + (9 * 32 + 1) + (N_OOR * 5 + 65) + (N_PIPE * 4 + 1);

    localparam hburst_t INCR_KINDS [4] = '{INCR4, INCR8, INCR16, INCR};
    localparam hburst_t WRAP_KINDS [3] = '{WRAP4, WRAP8, WRAP16};

    logic              clk;
    logic              hresetn;
    logic              hsel;
    logic              hwrite;
    htrans_t           htrans;
    hburst_t           hburst;
    hsize_t            hsize;
    logic [ADDR_W-1:0] haddr;
    logic [DATA_W-1:0] hwdata;
    logic              hready;
    hresp_t            hresp;
    logic [DATA_W-1:0] hrdata;

    // reference model and the beat now in its data phase
    logic [7:0]        model_mem [MEM_BYTES];
    longint unsigned   model_next;
    logic              pend_valid;
    logic              pend_write;
    logic              pend_err;
    int                pend_nbytes;
    int                pend_addr [4];
    logic [DATA_W-1:0] pend_wdata;

    logic [31:0]       rng_state;
    int                checks;
    int                errors;

    tb_clk_gen u_clk_gen (
        .clk     (clk),
        .hresetn (hresetn)
    );

    ahb_slave u_dut (
        .clk     (clk),
        .hresetn (hresetn),
        .hsel    (hsel),
        .hwrite  (hwrite),
        .htrans  (htrans),
        .hburst  (hburst),
        .hsize   (hsize),
        .haddr   (haddr),
        .hwdata  (hwdata),
        .hready  (hready),
        .hresp   (hresp),
        .hrdata  (hrdata)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // 2 to the power hsize
    function automatic int bytes_of(hsize_t sz);
        return 1 << int'(sz);
    endfunction

    function automatic int wrap_beats(hburst_t bu);
        case (bu)
            WRAP4:   return 4;
            WRAP8:   return 8;
            WRAP16:  return 16;
            default: return 0;
        endcase
    endfunction

    function automatic hsize_t random_size();
        return hsize_t'(next_random() % 3);
    endfunction

    // aligned start in 0 .. limit - size
    function automatic logic [ADDR_W-1:0] aligned_addr(hsize_t sz, int limit);
        return (next_random() % (limit / bytes_of(sz))) * bytes_of(sz);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_data_phase();
        logic [DATA_W-1:0] exp_rdata;
        exp_rdata = '0;
        if (pend_valid && !pend_write && !pend_err)
        begin
            for (int k = 0; k < pend_nbytes; k++)
                exp_rdata[8*k +: 8] = model_mem[pend_addr[k]];
        end
        check_value("hready", 32'(hready), 32'd1);
        check_value("hresp", 32'(hresp), (pend_valid && pend_err) ? 32'(ERROR) : 32'(OKAY));
        check_value("hrdata", hrdata, exp_rdata);
        // memory takes the write at the end of this data phase
        if (pend_valid && pend_write && !pend_err)
        begin
            for (int k = 0; k < pend_nbytes; k++)
                model_mem[pend_addr[k]] = pend_wdata[8*k +: 8];
        end
    endtask

    // one clock: new address phase, data phase of the previous beat
    task automatic run_beat(input htrans_t tr, input logic wr, input hburst_t bu,
                            input hsize_t sz, input logic [ADDR_W-1:0] addr,
                            input logic sel = 1'b1);
        longint unsigned a;
        longint unsigned blk;
        int              bound;
        int              off;
        @(posedge clk);
        hsel   <= sel;
        htrans <= tr;
        hwrite <= wr;
        hburst <= bu;
        hsize  <= sz;
        haddr  <= addr;
        hwdata <= pend_wdata;
        @(negedge clk);
        check_data_phase();
        pend_valid = sel && (tr == NONSEQ || tr == SEQ);
        pend_wdata = next_random();
        if (pend_valid)
        begin
            a           = (tr == NONSEQ) ? {32'd0, addr} : model_next;
            pend_write  = wr;
            pend_nbytes = bytes_of(sz);
            pend_err    = (a + longint'(pend_nbytes)) > longint'(MEM_BYTES);
            bound       = wrap_beats(bu) * pend_nbytes;
            if (bound > 0)
            begin
                blk = a - (a % longint'(bound));
                off = int'(a % longint'(bound));
                for (int k = 0; k < 4; k++)
                    pend_addr[k] = int'((blk + longint'((off + k) % bound)) % MEM_BYTES);
                model_next = blk + longint'((off + pend_nbytes) % bound);
            end
            else
            begin
                for (int k = 0; k < 4; k++)
                    pend_addr[k] = int'((a + longint'(k)) % MEM_BYTES);
                model_next = a + longint'(pend_nbytes);
            end
        end
    endtask

    // seq beats carry junk on haddr
    task automatic run_burst(input logic wr, input hburst_t bu, input hsize_t sz,
                             input logic [ADDR_W-1:0] start, input int len);
        for (int i = 0; i < len; i++)
            run_beat(i == 0 ? NONSEQ : SEQ, wr, bu, sz, i == 0 ? start : next_random());
    endtask

    task automatic finish_test(input string name, input int errs_before);
        run_beat(IDLE, 1'b0, SINGLE, SIZE_BYTE, next_random());
        $display("test %-18s done, %0d mismatches", name, errors - errs_before);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial
    begin
        int                errs;
        int                len;
        int                nb;
        int                bound;
        int                gap;
        hburst_t           bu;
        hsize_t            sz;
        logic [ADDR_W-1:0] addr;
        rng_state  = 32'd50;
        checks     = 0;
        errors     = 0;
        model_next = 0;
        pend_valid = 1'b0;
        pend_wdata = '0;
        for (int i = 0; i < MEM_BYTES; i++)
            model_mem[i] = MEM_INIT_BYTE;
        hsel   <= 1'b0;
        hwrite <= 1'b0;
        htrans <= IDLE;
        hburst <= SINGLE;
        hsize  <= SIZE_BYTE;
        haddr  <= '0;
        hwdata <= '0;

        errs = errors;
        @(negedge clk);
        while (!hresetn)
        begin
            check_value("hready", 32'(hready), 32'd0);
            @(negedge clk);
        end
        run_beat(NONSEQ, 1'b0, SINGLE, SIZE_WORD, aligned_addr(SIZE_WORD, MEM_BYTES));
        finish_test("reset_state", errs);

        // small window so reads hit earlier writes
        errs = errors;
        repeat (N_SINGLE)
        begin
            sz = random_size();
            run_beat(NONSEQ, next_random() % 2 == 0, SINGLE, sz, aligned_addr(sz, 64));
        end
        finish_test("single_transfers", errs);

        errs = errors;
        repeat (N_INCR)
        begin
            sz   = random_size();
            nb   = bytes_of(sz);
            bu   = INCR_KINDS[next_random() % 4];
            len  = (bu == INCR4) ? 4 : (bu == INCR8) ? 8 : (bu == INCR16) ? 16
                 : 1 + int'(next_random() % 16);
            addr = aligned_addr(sz, MEM_BYTES - (len - 1) * nb);
            run_burst(1'b1, bu, sz, addr, len);
            run_burst(1'b0, bu, sz, addr, len);
        end
        finish_test("incr_bursts", errs);

        // start one to three beats before the top of the boundary
        errs = errors;
        foreach (WRAP_KINDS[w])
            for (int s = 0; s < 3; s++)
            begin
                sz    = hsize_t'(s);
                nb    = bytes_of(sz);
                len   = wrap_beats(WRAP_KINDS[w]);
                bound = len * nb;
                addr  = (next_random() % (MEM_BYTES / bound)) * bound
                      + bound - nb * (1 + int'(next_random() % 3));
                run_burst(1'b1, WRAP_KINDS[w], sz, addr, len);
                run_burst(1'b0, WRAP_KINDS[w], sz, addr, len);
            end
        finish_test("wrap_bursts", errs);

        errs = errors;
        repeat (N_OOR)
        begin
            sz = random_size();
            nb = bytes_of(sz);
            // low bits alias real bytes
            run_beat(NONSEQ, next_random() % 2 == 0, SINGLE, sz,
                     (next_random() | 32'h100) & ~(nb - 1));
            run_burst(1'b1, INCR4, sz, MEM_BYTES - 2 * nb, 4);
        end
        for (int a = 0; a < MEM_BYTES; a += 4)
            run_beat(NONSEQ, 1'b0, SINGLE, SIZE_WORD, a);
        finish_test("out_of_range", errs);

        errs = errors;
        repeat (N_PIPE)
        begin
            sz   = random_size();
            addr = aligned_addr(sz, MEM_BYTES);
            run_beat(NONSEQ, 1'b1, SINGLE, sz, addr);
            // gaps are idle, busy or an unselected nonseq
            repeat (next_random() % 3)
            begin
                gap = int'(next_random() % 3);
                run_beat(gap == 0 ? IDLE : (gap == 1 ? BUSY : NONSEQ),
                         next_random() % 2 == 0, INCR, sz, next_random(), gap != 2);
            end
            run_beat(NONSEQ, 1'b0, SINGLE, sz, addr);
        end
        finish_test("pipelining", errs);

        $display("checks %0d, mismatches %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        #((TOTAL_BEATS + 100) * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TOTAL_BEATS + 100);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic hresetn
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset released on a rising edge
    initial
    begin
        hresetn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        hresetn <= 1'b1;
    end

endmodule

//--- ahb_slave.sv
`timescale 1ns/100ps

module ahb_slave (
    input  logic                       clk,
    input  logic                       hresetn,
    input  logic                       hsel,
    input  logic                       hwrite,
    input  ahb_pkg::htrans_t           htrans,
    input  ahb_pkg::hburst_t           hburst,
    input  ahb_pkg::hsize_t            hsize,
    input  logic [ahb_pkg::ADDR_W-1:0] haddr,
    input  logic [ahb_pkg::DATA_W-1:0] hwdata,
    output logic                       hready,
    output ahb_pkg::hresp_t            hresp,
    output logic [ahb_pkg::DATA_W-1:0] hrdata
);

    import ahb_pkg::*;
    import slave_mem_pkg::*;

    // address phase to data phase
    logic              dp_valid;
    logic              dp_write;
    logic              dp_err;
    logic [MEM_AW-1:0] dp_addr;
    hsize_t            dp_size;
    logic [MEM_AW-1:0] dp_mask;

    ahb_addr_phase u_addr (
        .clk      (clk),
        .hresetn  (hresetn),
        .hsel     (hsel),
        .hwrite   (hwrite),
        .htrans   (htrans),
        .hburst   (hburst),
        .hsize    (hsize),
        .haddr    (haddr),
        .dp_valid (dp_valid),
        .dp_write (dp_write),
        .dp_err   (dp_err),
        .dp_addr  (dp_addr),
        .dp_size  (dp_size),
        .dp_mask  (dp_mask)
    );

    byte_mem_stage u_mem (
        .clk      (clk),
        .hresetn  (hresetn),
        .dp_valid (dp_valid),
        .dp_write (dp_write),
        .dp_err   (dp_err),
        .dp_addr  (dp_addr),
        .dp_size  (dp_size),
        .dp_mask  (dp_mask),
        .hwdata   (hwdata),
        .hready   (hready),
        .hresp    (hresp),
        .hrdata   (hrdata)
    );

endmodule

//--- byte_mem_stage.sv
`timescale 1ns/100ps

module byte_mem_stage (
    input  logic                             clk,
    input  logic                             hresetn,
    input  logic                             dp_valid,
    input  logic                             dp_write,
    input  logic                             dp_err,
    input  logic [slave_mem_pkg::MEM_AW-1:0] dp_addr,
    input  ahb_pkg::hsize_t                  dp_size,
    input  logic [slave_mem_pkg::MEM_AW-1:0] dp_mask,
    input  logic [ahb_pkg::DATA_W-1:0]       hwdata,
    output logic                             hready,
    output ahb_pkg::hresp_t                  hresp,
    output logic [ahb_pkg::DATA_W-1:0]       hrdata
);

    import ahb_pkg::*;
    import slave_mem_pkg::*;

    logic [7:0]        mem [MEM_BYTES];
    logic [MEM_AW-1:0] byte_addr [BYTES_PER_WORD];
    logic [2:0]        nbytes;
    logic              wr_en;
    logic              rd_en;

    assign nbytes = size_bytes(dp_size);

    // an errored beat touches nothing
    assign wr_en = dp_valid && dp_write && !dp_err;
    assign rd_en = dp_valid && !dp_write && !dp_err;

    // byte k sits at dp_addr + k under the wrap mask
    always_comb
    begin
        for (int k = 0; k < BYTES_PER_WORD; k++)
        begin
            byte_addr[k] = MEM_AW'(wrap_incr(ADDR_W'(dp_addr), ADDR_W'(k),
                                             ADDR_W'(dp_mask)));
        end
    end

    //////////////////////////////
    // byte array
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            for (int i = 0; i < MEM_BYTES; i++)
            begin
                mem[i] <= MEM_INIT_BYTE;
            end
        end
        else if (wr_en)
        begin
            // low-justified write data
            for (int k = 0; k < BYTES_PER_WORD; k++)
            begin
                if (k < int'(nbytes))
                begin
                    mem[byte_addr[k]] <= hwdata[8*k +: 8];
                end
            end
        end
    end

    // read data, unused bytes zero
    always_comb
    begin
        hrdata = '0;
        if (rd_en)
        begin
            for (int k = 0; k < BYTES_PER_WORD; k++)
            begin
                if (k < int'(nbytes))
                begin
                    hrdata[8*k +: 8] = mem[byte_addr[k]];
                end
            end
        end
    end

    //////////////////////////////
    // response
    //////////////////////////////

    assign hresp = (dp_valid && dp_err) ? ERROR : OKAY;

    // zero wait states, low only in reset
    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            hready <= 1'b0;
        end
        else
        begin
            hready <= 1'b1;
        end
    end

endmodule

//--- ahb_addr_phase.sv
`timescale 1ns/100ps

module ahb_addr_phase (
    input  logic                             clk,
    input  logic                             hresetn,
    input  logic                             hsel,
    input  logic                             hwrite,
    input  ahb_pkg::htrans_t                 htrans,
    input  ahb_pkg::hburst_t                 hburst,
    input  ahb_pkg::hsize_t                  hsize,
    input  logic [ahb_pkg::ADDR_W-1:0]       haddr,
    output logic                             dp_valid,
    output logic                             dp_write,
    output logic                             dp_err,
    output logic [slave_mem_pkg::MEM_AW-1:0] dp_addr,
    output ahb_pkg::hsize_t                  dp_size,
    output logic [slave_mem_pkg::MEM_AW-1:0] dp_mask
);

    import ahb_pkg::*;
    import slave_mem_pkg::*;

    logic              accept;
    logic [ADDR_W-1:0] seq_addr;
    logic [ADDR_W-1:0] beat_addr;
    logic [ADDR_W-1:0] next_addr;
    logic [ADDR_W-1:0] wrap_mask;
    logic              in_range;

    // busy and idle beats are no transfer
    assign accept = hsel && (htrans == NONSEQ || htrans == SEQ);

    // seq beats follow our own address, haddr is ignored
    assign beat_addr = (htrans == SEQ) ? seq_addr : haddr;

    burst_addr_calc u_calc (
        .beat_addr (beat_addr),
        .hburst    (hburst),
        .hsize     (hsize),
        .next_addr (next_addr),
        .wrap_mask (wrap_mask),
        .in_range  (in_range)
    );

    //////////////////////////////
    // data-phase control
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_err   <= 1'b0;
        end
        else
        begin
            dp_valid <= accept;
            dp_write <= accept && hwrite;
            dp_err   <= accept && !in_range;
        end
    end

    // address and size of the accepted beat
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            seq_addr <= next_addr;
            dp_addr  <= beat_addr[MEM_AW-1:0];
            dp_size  <= hsize;
            dp_mask  <= wrap_mask[MEM_AW-1:0];
        end
    end

endmodule

//--- burst_addr_calc.sv
`timescale 1ns/100ps

module burst_addr_calc (
    input  logic [ahb_pkg::ADDR_W-1:0] beat_addr,
    input  ahb_pkg::hburst_t           hburst,
    input  ahb_pkg::hsize_t            hsize,
    output logic [ahb_pkg::ADDR_W-1:0] next_addr,
    output logic [ahb_pkg::ADDR_W-1:0] wrap_mask,
    output logic                       in_range
);

    import ahb_pkg::*;
    import slave_mem_pkg::*;

    logic [2:0] nbytes;
    logic [4:0] beats;
    logic [6:0] boundary;
    logic       is_wrap;

    assign nbytes = size_bytes(hsize);

    //////////////////////////////
    // burst decode
    //////////////////////////////

    always_comb
    begin
        beats   = 5'd0;
        is_wrap = 1'b0;
        case (hburst)
            WRAP4:
            begin
                beats   = 5'd4;
                is_wrap = 1'b1;
            end
            WRAP8:
            begin
                beats   = 5'd8;
                is_wrap = 1'b1;
            end
            WRAP16:
            begin
                beats   = 5'd16;
                is_wrap = 1'b1;
            end
            // single and incrementing bursts never roll over
            default:
            begin
                beats   = 5'd0;
                is_wrap = 1'b0;
            end
        endcase
    end

    // wrap boundary in bytes, at most 16 x 4
    assign boundary = 7'(beats) * 7'(nbytes);

    assign wrap_mask = is_wrap ? ADDR_W'(boundary - 7'd1) : '1;

    //////////////////////////////
    // next beat and range
    //////////////////////////////

    // plain add when the mask is all ones
    assign next_addr = wrap_incr(beat_addr, ADDR_W'(nbytes), wrap_mask);
    assign in_range  = in_mem(beat_addr, nbytes);

endmodule

//--- slave_mem_pkg.sv
package slave_mem_pkg;

    import ahb_pkg::*;

    // byte array geometry
    localparam int         MEM_BYTES      = 256;
    localparam int         MEM_AW         = 8;
    localparam logic [7:0] MEM_INIT_BYTE  = 8'd12;
    localparam int         BYTES_PER_WORD = 4;

    // step an address, bits under mask roll over, bits above are kept
    function automatic logic [ADDR_W-1:0] wrap_incr(logic [ADDR_W-1:0] base,
                                                    logic [ADDR_W-1:0] step,
                                                    logic [ADDR_W-1:0] mask);
        return (base & ~mask) | ((base + step) & mask);
    endfunction

    // last byte of the beat must still sit inside the array
    function automatic logic in_mem(logic [ADDR_W-1:0] base, logic [2:0] nbytes);
        logic [ADDR_W:0] last;
        last = {1'b0, base} + (ADDR_W+1)'(nbytes) - 1'b1;
        return last < (ADDR_W+1)'(MEM_BYTES);
    endfunction

endpackage

//--- ahb_pkg.sv
package ahb_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // transfer type, same numbering as the existing bus
    typedef enum logic [1:0] {
        NONSEQ = 2'd0,
        SEQ    = 2'd1,
        BUSY   = 2'd2,
        IDLE   = 2'd3
    } htrans_t;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_t;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hsize_t;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_t;

    // bytes moved by one beat
    function automatic logic [2:0] size_bytes(hsize_t size);
        case (size)
            SIZE_BYTE: return 3'd1;
            SIZE_HALF: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

endpackage
